//--- Bender.yml
package:
  name: hdc_encoder

sources:
  - include_dirs:
      - source
    files:
      - source/axil_pkg.sv
      - source/hdc_pkg.sv
      - source/axil_slave.sv
      - source/ctrl_regs.sv
      - source/xorshift_prng.sv
      - source/item_sequencer.sv
      - source/hdc_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/hdc_checker.sv
      - sim/tb_hdc_top.sv

//--- sim/hdc_checker.sv
`timescale 1ns/1ns
`include "hdc_settings.svh"

module hdc_checker
    import axil_pkg::*;
    import hdc_pkg::*;
(
    input logic      AXIS_ACLK,
    input logic      S_AXI_ARESETN,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp,
    input item_wr_t  item_wr,
    input logic      gen
);

    int assert_fails = 0;

    // previous item address within one gen run
    logic                    seen_item;
    logic [`HDC_ITEM_AW-1:0] last_addr;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            seen_item <= 1'b0;
            last_addr <= '0;
        end else if (item_wr.strobe) begin
            seen_item <= 1'b1;
            last_addr <= item_wr.addr;
        end
    end

    // ----------------------------------------
    // bus handshakes
    // ----------------------------------------
    bvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin
            assert_fails++;
            $error("bvalid dropped before bready");
        end

    // data must not move under back-pressure
    rvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else begin
            assert_fails++;
            $error("rvalid or rdata changed before rready");
        end

    // ----------------------------------------
    // item writes
    // ----------------------------------------
    strobe_pulse: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_wr.strobe |=> !item_wr.strobe)
        else begin
            assert_fails++;
            $error("item strobe longer than one cycle");
        end

    first_addr: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_wr.strobe && !seen_item |-> item_wr.addr == '0)
        else begin
            assert_fails++;
            $error("first item address is not zero");
        end

    addr_step: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_wr.strobe && seen_item |-> item_wr.addr == last_addr + 1'b1)
        else begin
            assert_fails++;
            $error("item address did not step by one");
        end

    no_strobe_idle: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !gen |-> !item_wr.strobe)
        else begin
            assert_fails++;
            $error("item strobe while gen is low");
        end

endmodule

bind hdc_top hdc_checker u_hdc_checker (
    .AXIS_ACLK     (AXIS_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .item_wr       (item_wr),
    .gen           (gen)
);

//--- sim/tb_hdc_top.sv
`timescale 1ns/1ns
`include "hdc_settings.svh"

module tb_hdc_top
    import axil_pkg::*;
    import hdc_pkg::*;
();

    localparam int PERIOD    = 100;
    localparam int NUM_RUNS  = 4;
    localparam int MAX_COUNT = 12;
    localparam int CW        = `HDC_HV_WORDS * 32;
    // generation time of all runs plus room for bus traffic
    localparam int TIMEOUT_NS = NUM_RUNS * (MAX_COUNT + 1) * `HDC_HV_WORDS * PERIOD + 200000;

    logic      AXIS_ACLK = 1'b0;
    logic      S_AXI_ARESETN;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    item_wr_t  item_wr;

    int errors = 0;
    int checks = 0;
    int cycle  = 0;

    // reference xorshift128 state
    logic [31:0] mx;
    logic [31:0] my;
    logic [31:0] mz;
    logic [31:0] mw;

    // observed item writes
    logic [`HDC_ITEM_AW-1:0] seen_addr[$];
    hv_t                     seen_hv[$];
    int                      seen_cycle[$];

    hdc_top u_hdc_top (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .item_wr       (item_wr)
    );

    always #(PERIOD / 2) AXIS_ACLK = ~AXIS_ACLK;

    always @(posedge AXIS_ACLK) begin
        cycle <= cycle + 1;
    end

    // item port sampled mid-cycle
    always @(negedge AXIS_ACLK) begin
        if (item_wr.strobe) begin
            seen_addr.push_back(item_wr.addr);
            seen_hv.push_back(item_wr.hv);
            seen_cycle.push_back(cycle);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check_value(input logic [CW-1:0] got, input logic [CW-1:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // rising edge, then the drive point
    task automatic next_cycle();
        @(posedge AXIS_ACLK);
        #10;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic load_seed();
        mx = `HDC_XOR_X;
        my = `HDC_XOR_Y;
        mz = `HDC_XOR_Z;
        mw = `HDC_XOR_W;
    endtask

    // output is the current w, then one step
    task automatic model_word(output logic [31:0] word);
        logic [31:0] t;
        word = mw;
        t    = mx ^ (mx << 11);
        mx   = my;
        my   = mz;
        mz   = mw;
        mw   = mw ^ (mw >> 19) ^ t ^ (t >> 8);
    endtask

    // ----------------------------------------
    // AXI-Lite master
    // ----------------------------------------
    task automatic send_addr(input logic [31:0] addr);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        while (!axil_rsp.awready) next_cycle();
        next_cycle();
        axil_req.awvalid = 1'b0;
    endtask

    task automatic send_data(input logic [31:0] data);
        axil_req.wdata  = data;
        axil_req.wvalid = 1'b1;
        while (!axil_rsp.wready) next_cycle();
        next_cycle();
        axil_req.wvalid = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        int order;
        int delay;
        order = $urandom_range(0, 2);
        if (order == 0) begin
            // address and data together
            axil_req.awaddr  = addr;
            axil_req.wdata   = data;
            axil_req.awvalid = 1'b1;
            axil_req.wvalid  = 1'b1;
            while (!(axil_rsp.awready && axil_rsp.wready)) next_cycle();
            next_cycle();
            axil_req.awvalid = 1'b0;
            axil_req.wvalid  = 1'b0;
        end else if (order == 1) begin
            send_addr(addr);
            // address taken, waiting for data only
            check_value(axil_rsp.awready, 1'b0, "awready low after address");
            idle_cycles($urandom_range(0, 3));
            send_data(data);
        end else begin
            send_data(data);
            // data taken, waiting for address only
            check_value(axil_rsp.wready, 1'b0, "wready low after data");
            idle_cycles($urandom_range(0, 3));
            send_addr(addr);
        end
        // response under bready back-pressure
        delay = $urandom_range(0, 4);
        while (!axil_rsp.bvalid) next_cycle();
        idle_cycles(delay);
        check_value(axil_rsp.bvalid, 1'b1, "bvalid held");
        check_value(axil_rsp.bresp, 2'b00, "bresp");
        axil_req.bready = 1'b1;
        next_cycle();
        axil_req.bready = 1'b0;
        // only one response per write
        check_value(axil_rsp.bvalid, 1'b0, "single write response");
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int delay;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        while (!axil_rsp.arready) next_cycle();
        next_cycle();
        axil_req.arvalid = 1'b0;
        // arready only in idle
        check_value(axil_rsp.arready, 1'b0, "arready low while busy");
        while (!axil_rsp.rvalid) next_cycle();
        data  = axil_rsp.rdata;
        delay = $urandom_range(0, 4);
        repeat (delay) begin
            next_cycle();
            check_value(axil_rsp.rvalid, 1'b1, "rvalid held");
            check_value(axil_rsp.rdata, data, "rdata stable");
        end
        check_value(axil_rsp.rresp, 2'b00, "rresp");
        axil_req.rready = 1'b1;
        next_cycle();
        axil_req.rready = 1'b0;
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] data;
        bus_read(addr, data);
        check_value(data, exp, what);
    endtask

    // ----------------------------------------
    // one gen run against the model
    // ----------------------------------------
    task automatic gen_run(input int count, input logic run_bit);
        hv_t         exp_hv;
        logic [31:0] word;
        seen_addr.delete();
        seen_hv.delete();
        seen_cycle.delete();
        bus_write(32'(`HDC_REG_COUNT), 32'(count));
        bus_write(32'(`HDC_REG_MODE), {30'd0, run_bit, 1'b1});
        while (seen_addr.size() < count + 1) next_cycle();
        // late extra writes would show up here
        idle_cycles(2 * `HDC_HV_WORDS);
        check_value(seen_addr.size(), count + 1, "item write count");
        for (int i = 0; i < seen_addr.size() && i <= count; i++) begin
            for (int k = 0; k < `HDC_HV_WORDS; k++) begin
                model_word(word);
                exp_hv[k] = word;
            end
            check_value(seen_addr[i], i, "item address");
            check_value(seen_hv[i], exp_hv, "item vector");
            if (i > 0) begin
                check_value(seen_cycle[i] - seen_cycle[i-1], `HDC_HV_WORDS, "item spacing");
            end
        end
        // gen is still high at the clearing edge, one more step
        model_word(word);
        read_expect(32'(`HDC_REG_MODE), {30'd0, run_bit, 1'b0}, "gen cleared");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] value;
        int          total;
        void'($urandom(49021));
        axil_req      = '0;
        S_AXI_ARESETN = 1'b0;
        load_seed();
        repeat (5) @(posedge AXIS_ACLK);
        #10;
        S_AXI_ARESETN = 1'b1;
        next_cycle();

        // bus and item port state out of reset
        check_value(axil_rsp.awready, 1'b1, "awready after reset");
        check_value(axil_rsp.wready, 1'b1, "wready after reset");
        check_value(axil_rsp.arready, 1'b1, "arready after reset");
        check_value(axil_rsp.bvalid, 1'b0, "bvalid after reset");
        check_value(axil_rsp.rvalid, 1'b0, "rvalid after reset");
        check_value(item_wr.strobe, 1'b0, "item strobe after reset");

        // reset values and the page outside bits 11:10
        read_expect(32'(`HDC_REG_MODE), 32'd0, "mode after reset");
        bus_write(32'(`HDC_REG_MODE), 32'd2);
        read_expect(32'(`HDC_REG_MODE), 32'd2, "run bit readback");
        // last read data was nonzero
        read_expect(32'h0000_0800, 32'd0, "read outside page");
        // would set gen if decoded
        bus_write(32'h0000_0400, 32'd1);
        read_expect(32'(`HDC_REG_MODE), 32'd2, "write outside page ignored");
        bus_write(32'(`HDC_REG_COUNT), 32'd5);
        read_expect(32'(`HDC_REG_COUNT), 32'd0, "count offset reads zero");

        // random channel order and ready delays
        for (int i = 0; i < 6; i++) begin
            value = $urandom_range(0, 1) << 1;
            bus_write(32'(`HDC_REG_MODE), value);
            idle_cycles($urandom_range(0, 3));
            read_expect(32'(`HDC_REG_MODE), value, "mode readback");
        end

        // gen runs, reseed before the third one
        for (int run = 0; run < NUM_RUNS; run++) begin
            if (run == 2) begin
                bus_write(32'(`HDC_REG_RESEED), 32'd1);
                idle_cycles($urandom_range(1, 3));
                bus_write(32'(`HDC_REG_RESEED), 32'd0);
                load_seed();
            end
            gen_run($urandom_range(0, MAX_COUNT), $urandom_range(0, 1));
            idle_cycles($urandom_range(0, 4));
        end

        total = errors + u_hdc_top.u_hdc_checker.assert_fails;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, u_hdc_top.u_hdc_checker.assert_fails);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- source/axil_pkg.sv
`include "hdc_settings.svh"

package axil_pkg;

    // master to slave, all five channels
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // channel FSM states
    typedef enum logic [2:0] {
        idle,
        addr_only,
        data_only,
        write_resp,
        read_fetch,
        read_resp
    } axil_state_e;

    // register side strobes, word address = byte address 11:2
    typedef struct packed {
        logic        strobe;
        logic [9:0]  addr;
        logic [31:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic       strobe;
        logic [9:0] addr;
    } reg_rd_t;

endpackage

//--- source/axil_slave.sv
`timescale 1ns/1ns
`include "hdc_settings.svh"

module axil_slave
    import axil_pkg::*;
(
    input  logic      AXIS_ACLK,
    input  logic      S_AXI_ARESETN,
    input  axil_req_t req,
    output axil_rsp_t rsp,
    output reg_wr_t   reg_wr,
    output reg_rd_t   reg_rd
);

    axil_state_e state;

    // word addresses, byte address bits 11:2
    logic [9:0]  wr_addr;
    logic [9:0]  rd_addr;
    logic [31:0] wr_data;

    // ----------------------------------------
    // channel FSM
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state   <= idle;
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            case (state)
                idle: begin
                    // write wins over read when both arrive
                    if (req.awvalid && req.wvalid) begin
                        state   <= write_resp;
                        wr_addr <= req.awaddr[11:2];
                        wr_data <= req.wdata;
                    end else if (req.awvalid) begin
                        state   <= addr_only;
                        wr_addr <= req.awaddr[11:2];
                    end else if (req.wvalid) begin
                        state   <= data_only;
                        wr_data <= req.wdata;
                    end else if (req.arvalid) begin
                        state   <= read_fetch;
                        rd_addr <= req.araddr[11:2];
                    end
                end
                // waiting for data
                addr_only: begin
                    if (req.wvalid) begin
                        state   <= write_resp;
                        wr_data <= req.wdata;
                    end
                end
                // waiting for address
                data_only: begin
                    if (req.awvalid) begin
                        state   <= write_resp;
                        wr_addr <= req.awaddr[11:2];
                    end
                end
                write_resp: begin
                    if (req.bready) begin
                        state <= idle;
                    end
                end
                // register block samples rdata here
                read_fetch: begin
                    state <= read_resp;
                end
                read_resp: begin
                    if (req.rready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // bus response
    // ----------------------------------------
    assign rsp.awready = (state == idle) || (state == data_only);
    assign rsp.wready  = (state == idle) || (state == addr_only);
    assign rsp.arready = (state == idle);
    assign rsp.bvalid  = (state == write_resp);
    assign rsp.rvalid  = (state == read_resp);
    assign rsp.bresp   = 2'b00;
    assign rsp.rresp   = 2'b00;
    // read data comes from the register block
    assign rsp.rdata   = 32'd0;

    // register strobes, only inside the low 1 KiB
    // write lands on the response handshake
    assign reg_wr.strobe = (state == write_resp) && req.bready && (wr_addr[9:8] == 2'b00);
    assign reg_wr.addr   = wr_addr;
    assign reg_wr.data   = wr_data;

    // read address stays held until the next accepted read
    assign reg_rd.strobe = (state == read_fetch) && (rd_addr[9:8] == 2'b00);
    assign reg_rd.addr   = rd_addr;

endmodule

//--- source/ctrl_regs.sv
`timescale 1ns/1ns
`include "hdc_settings.svh"

module ctrl_regs
    import axil_pkg::*;
    import hdc_pkg::*;
(
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  reg_wr_t     reg_wr,
    input  reg_rd_t     reg_rd,
    input  item_wr_t    item_wr,
    output logic        gen,
    output logic        reseed,
    output logic [31:0] rdata
);

    mode_t                   mode;
    logic [`HDC_ITEM_AW-1:0] item_count;
    ctrl_word_u              wr_word;

    // byte offsets within the register page
    logic [9:0] wr_offset;
    logic [9:0] rd_offset;

    assign wr_word   = reg_wr.data;
    assign wr_offset = {reg_wr.addr[7:0], 2'b00};
    assign rd_offset = {reg_rd.addr[7:0], 2'b00};

    // ----------------------------------------
    // write side
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            mode       <= '0;
            item_count <= '0;
            reseed     <= 1'b0;
        end else begin
            // final item written, leave gen mode
            if (mode.gen && item_wr.strobe && (item_wr.addr == item_count)) begin
                mode.gen <= 1'b0;
            end
            // a mode write at the same edge wins
            if (reg_wr.strobe) begin
                case (wr_offset)
                    `HDC_REG_MODE: begin
                        mode <= wr_word.m.mode;
                    end
                    // last item index, count+1 items in total
                    `HDC_REG_COUNT: begin
                        item_count <= wr_word.c.count;
                    end
                    `HDC_REG_RESEED: begin
                        reseed <= reg_wr.data[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign gen = mode.gen;

    // ----------------------------------------
    // read side
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rdata <= '0;
        end else if (reg_rd.strobe) begin
            // only the mode register reads back
            if (rd_offset == `HDC_REG_MODE) begin
                rdata <= {30'd0, mode};
            end else begin
                rdata <= '0;
            end
        end else if (reg_rd.addr[9:8] != 2'b00) begin
            // held read address outside the page
            // no strobe there, so force zero
            rdata <= '0;
        end
    end

endmodule

//--- source/hdc_pkg.sv
`include "hdc_settings.svh"

package hdc_pkg;

    // ----------------------------------------
    // hypervector and item memory port
    // ----------------------------------------

    // word k sits in bits 32k+31 to 32k
    typedef logic [`HDC_HV_WORDS-1:0][31:0] hv_t;

    typedef struct packed {
        logic                    strobe;
        logic [`HDC_ITEM_AW-1:0] addr;
        hv_t                     hv;
    } item_wr_t;

    // ----------------------------------------
    // control register words
    // ----------------------------------------

    // accelerator mode
    // write 2 for run, 1 for gen
    typedef struct packed {
        logic run;
        logic gen;
    } mode_t;

    // mode register view
    typedef struct packed {
        logic [29:0] rsvd;
        mode_t       mode;
    } mode_word_t;

    // item count register view
    typedef struct packed {
        logic [31-`HDC_ITEM_AW:0] rsvd;
        logic [`HDC_ITEM_AW-1:0]  count;
    } count_word_t;

    // one bus write word, two decodes
    typedef union packed {
        mode_word_t  m;
        count_word_t c;
    } ctrl_word_u;

endpackage

//--- source/hdc_settings.svh
`ifndef HDC_SETTINGS_SVH
`define HDC_SETTINGS_SVH

// ----------------------------------------
// hypervector geometry
// ----------------------------------------

// 32-bit words per hypervector (8 x 32 = 256 bits)
`define HDC_HV_WORDS 8
// item memory address width, up to 512 entries
`define HDC_ITEM_AW 9

// ----------------------------------------
// register map, byte offsets in low 10 bits
// ----------------------------------------
`define HDC_REG_MODE 10'd0
`define HDC_REG_COUNT 10'd4
`define HDC_REG_RESEED 10'd8

// xorshift128 seed words
`define HDC_XOR_X 32'd123456789
`define HDC_XOR_Y 32'd362436069
`define HDC_XOR_Z 32'd521288629
`define HDC_XOR_W 32'd88675123

`endif

//--- source/hdc_top.sv
`timescale 1ns/1ns
`include "hdc_settings.svh"

module hdc_top
    import axil_pkg::*;
    import hdc_pkg::*;
(
    input  logic      AXIS_ACLK,
    input  logic      S_AXI_ARESETN,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output item_wr_t  item_wr
);

    axil_rsp_t   slave_rsp;
    reg_wr_t     reg_wr;
    reg_rd_t     reg_rd;
    logic        gen;
    logic        reseed;
    logic [31:0] rdata;
    logic [31:0] rand_word;

    // ----------------------------------------
    // bus side
    // ----------------------------------------
    axil_slave u_axil_slave (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req           (axil_req),
        .rsp           (slave_rsp),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd)
    );

    ctrl_regs u_ctrl_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .item_wr       (item_wr),
        .gen           (gen),
        .reseed        (reseed),
        .rdata         (rdata)
    );

    // slave handshakes with register read data
    assign axil_rsp = '{
        awready: slave_rsp.awready,
        wready:  slave_rsp.wready,
        bvalid:  slave_rsp.bvalid,
        bresp:   slave_rsp.bresp,
        arready: slave_rsp.arready,
        rvalid:  slave_rsp.rvalid,
        rdata:   rdata,
        rresp:   slave_rsp.rresp
    };

    // ----------------------------------------
    // item generation
    // ----------------------------------------
    xorshift_prng u_xorshift_prng (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .reseed        (reseed),
        .rand_word     (rand_word)
    );

    item_sequencer u_item_sequencer (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (gen),
        .rand_word (rand_word),
        .item_wr   (item_wr)
    );

endmodule

//--- source/item_sequencer.sv
`timescale 1ns/1ns
`include "hdc_settings.svh"

module item_sequencer
    import hdc_pkg::*;
(
    input  logic        AXIS_ACLK,
    input  logic        gen,
    input  logic [31:0] rand_word,
    output item_wr_t    item_wr
);

    // counter width, at least one bit
    localparam int CW = (`HDC_HV_WORDS > 1) ? $clog2(`HDC_HV_WORDS) : 1;
    localparam logic [CW-1:0] LAST_WORD = CW'(`HDC_HV_WORDS - 1);

    // word slot filled at the next edge
    logic [CW-1:0] word_cnt;

    // ----------------------------------------
    // word counter and vector assembly
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            word_cnt   <= '0;
            item_wr.hv <= '0;
        end else begin
            // word k captured while counter is k
            item_wr.hv[word_cnt] <= rand_word;
            if (word_cnt == LAST_WORD) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // item write strobe and address
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            item_wr.strobe <= 1'b0;
            item_wr.addr   <= '0;
        end else begin
            // one cycle after the last word lands
            item_wr.strobe <= (word_cnt == LAST_WORD);
            // next item index after each write
            if (item_wr.strobe) begin
                item_wr.addr <= item_wr.addr + 1'b1;
            end
        end
    end

endmodule

//--- source/xorshift_prng.sv
`timescale 1ns/1ns
`include "hdc_settings.svh"

module xorshift_prng (
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        gen,
    input  logic        reseed,
    output logic [31:0] rand_word
);

    // xorshift128 state
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] z;
    logic [31:0] w;
    logic [31:0] t;

    assign t = x ^ (x << 11);

    always_ff @(posedge AXIS_ACLK) begin
        // reseed level keeps the state at the seed
        if (!S_AXI_ARESETN || reseed) begin
            x <= `HDC_XOR_X;
            y <= `HDC_XOR_Y;
            z <= `HDC_XOR_Z;
            w <= `HDC_XOR_W;
        end else if (gen) begin
            // one step per cycle, shift words down
            x <= y;
            y <= z;
            z <= w;
            w <= w ^ (w >> 19) ^ t ^ (t >> 8);
        end
    end

    // current w, not the next one
    assign rand_word = w;

endmodule

//--- tb.f
+incdir+source
source/axil_pkg.sv
source/hdc_pkg.sv
source/axil_slave.sv
source/ctrl_regs.sv
source/xorshift_prng.sv
source/item_sequencer.sv
source/hdc_top.sv
sim/hdc_checker.sv
sim/tb_hdc_top.sv
